// File: verilog/histogram_defs.svh
`ifndef HISTOGRAM_DEFS_SVH
`define HISTOGRAM_DEFS_SVH

// Width of one sample on the input stream
`define HIST_SAMPLE_WIDTH 16

// Bin index width, small enough to keep clear and dump short
`define HIST_ADDR_WIDTH 6

// One bin count, saturates at all ones
`define HIST_COUNT_WIDTH 8

`endif

// File: verilog/histogram_pkg.sv
`default_nettype none

`include "histogram_defs.svh"

package histogram_pkg;

  typedef logic [`HIST_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`HIST_ADDR_WIDTH-1:0]   bin_addr_t;
  typedef logic [`HIST_COUNT_WIDTH-1:0]  bin_count_t;

  // Accumulator FSM
  typedef enum logic [2:0] {
    hist_clear_start,
    hist_clear,
    hist_idle,
    hist_fetch,
    hist_settle
  } hist_state_t;

  typedef enum logic [1:0] {dump_off, dump_read, dump_wait, dump_send} dump_state_t;

endpackage

`default_nettype wire

// File: verilog/bin_ram_if.sv
`default_nettype none

interface bin_ram_if;
  import histogram_pkg::*;

  bin_addr_t  addr;
  bin_count_t wrdata;
  bin_count_t rddata; // Valid one cycle after addr
  logic       we;

  modport client (
    output addr,
    output wrdata,
    output we,
    input  rddata
  );

  modport memory (
    input  addr,
    input  wrdata,
    input  we,
    output rddata
  );

endinterface

`default_nettype wire

// File: verilog/bin_ram.sv
`default_nettype none

`include "histogram_defs.svh"

module bin_ram (
  input logic        aclk,
  bin_ram_if.memory  port_a,
  bin_ram_if.memory  port_b
);
  import histogram_pkg::*;

  localparam int unsigned DEPTH = 1 << `HIST_ADDR_WIDTH;

  bin_count_t mem [0:DEPTH-1];

  // Both ports may write, only port A does so in this design
  always_ff @(posedge aclk)
  begin
    if (port_a.we)
    begin
      mem[port_a.addr] <= port_a.wrdata;
    end
    if (port_b.we)
    begin
      mem[port_b.addr] <= port_b.wrdata;
    end
  end

  // Registered reads return the old contents on a same-cycle write
  always_ff @(posedge aclk)
  begin
    port_a.rddata <= mem[port_a.addr];
  end

  always_ff @(posedge aclk)
  begin
    port_b.rddata <= mem[port_b.addr];
  end

  // The two ports must never write the same bin in one cycle
  a_no_write_collision : assert property (@(posedge aclk)
    port_a.we && port_b.we |-> port_a.addr != port_b.addr);

endmodule

`default_nettype wire

// File: verilog/axis_histogram.sv
`default_nettype none

`include "histogram_defs.svh"

module axis_histogram (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  histogram_pkg::sample_t s_axis_tdata,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  bin_ram_if.client              ram
);
  import histogram_pkg::*;

  hist_state_t state;
  bin_addr_t   addr_reg;   // Clear pointer, then the bin being updated
  bin_addr_t   sample_bin;
  logic        saturated;
  logic        we;

  assign sample_bin = s_axis_tdata[`HIST_ADDR_WIDTH-1:0];
  assign saturated  = &ram.rddata;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state    <= hist_clear_start;
      addr_reg <= '0;
    end
    else
    begin
      case (state)
        hist_clear_start:
        begin
          addr_reg <= '0;
          state    <= hist_clear;
        end
        hist_clear:
        begin
          addr_reg <= addr_reg + 1'b1;
          if (&addr_reg)
          begin
            state <= hist_idle; // Last bin zeroed this cycle
          end
        end
        hist_idle:
        begin
          if (s_axis_tvalid)
          begin
            addr_reg <= sample_bin;
            state    <= hist_fetch;
          end
        end
        hist_fetch:
        begin
          state <= hist_settle;
        end
        hist_settle:
        begin
          state <= hist_idle;
        end
        default:
        begin
          state <= hist_clear_start;
        end
      endcase
    end
  end

  // The count read in the accept cycle is on rddata during fetch
  assign we = (state == hist_clear) || ((state == hist_fetch) && !saturated);

  assign ram.we     = we;
  assign ram.addr   = we ? addr_reg : sample_bin; // Idle reads straight from the sample
  assign ram.wrdata = (state == hist_fetch) ? ram.rddata + 1'b1 : '0;

  assign s_axis_tready = (state == hist_idle);

  // The increment lands on the bin that was accepted one cycle earlier
  a_write_accepted_bin : assert property (@(posedge aclk) disable iff (!aresetn)
    s_axis_tvalid && s_axis_tready |=> !ram.we || ram.addr == $past(sample_bin));

  // An update blocks the stream for exactly two cycles
  a_tready_gap : assert property (@(posedge aclk) disable iff (!aresetn)
    s_axis_tvalid && s_axis_tready |=> !s_axis_tready [*2] ##1 s_axis_tready);

endmodule

`default_nettype wire

// File: verilog/histogram_dump.sv
`default_nettype none

module histogram_dump (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      dump_start,
  output logic                      dump_busy,
  output histogram_pkg::bin_count_t m_axis_tdata,
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output logic                      m_axis_tlast,
  bin_ram_if.client                 ram
);
  import histogram_pkg::*;

  dump_state_t state;
  bin_addr_t   bin_cnt;
  bin_count_t  tdata_reg;
  logic        tvalid_reg;
  logic        tlast_reg;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state      <= dump_off;
      bin_cnt    <= '0;
      tvalid_reg <= 1'b0;
      tlast_reg  <= 1'b0;
    end
    else
    begin
      case (state)
        dump_off:
        begin
          if (dump_start)
          begin
            bin_cnt <= '0;
            state   <= dump_read;
          end
        end
        dump_read:
        begin
          state <= dump_wait; // Address is on the RAM this cycle
        end
        dump_wait:
        begin
          tvalid_reg <= 1'b1;
          tlast_reg  <= &bin_cnt;
          state      <= dump_send;
        end
        dump_send:
        begin
          if (m_axis_tready)
          begin
            tvalid_reg <= 1'b0;
            tlast_reg  <= 1'b0;
            bin_cnt    <= bin_cnt + 1'b1;
            state      <= tlast_reg ? dump_off : dump_read;
          end
        end
        default:
        begin
          state <= dump_off;
        end
      endcase
    end
  end

  // Count captured once per bin and held until the beat is taken
  always_ff @(posedge aclk)
  begin
    if (state == dump_wait)
    begin
      tdata_reg <= ram.rddata;
    end
  end

  assign ram.addr   = bin_cnt;
  assign ram.wrdata = '0;
  assign ram.we     = 1'b0; // Read-only port

  assign dump_busy     = (state != dump_off);
  assign m_axis_tdata  = tdata_reg;
  assign m_axis_tvalid = tvalid_reg;
  assign m_axis_tlast  = tlast_reg;

  // A stalled beat must not change under the consumer
  a_stable_when_stalled : assert property (@(posedge aclk) disable iff (!aresetn)
    m_axis_tvalid && !m_axis_tready |=>
      m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast));

endmodule

`default_nettype wire

// File: verilog/histogram_top.sv
`default_nettype none

`include "histogram_defs.svh"

module histogram_top (
  input  logic                         aclk,
  input  logic                         aresetn,

  input  logic [`HIST_SAMPLE_WIDTH-1:0] s_axis_tdata,
  input  logic                         s_axis_tvalid,
  output logic                         s_axis_tready,

  input  logic                         dump_start,
  output logic                         dump_busy,

  output logic [`HIST_COUNT_WIDTH-1:0]  m_axis_tdata,
  output logic                         m_axis_tvalid,
  input  logic                         m_axis_tready,
  output logic                         m_axis_tlast
);

  bin_ram_if ram_a (); // Accumulator side
  bin_ram_if ram_b (); // Dump side

  bin_ram ram_i (
    .aclk   (aclk),
    .port_a (ram_a),
    .port_b (ram_b)
  );

  axis_histogram acc_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .ram           (ram_a)
  );

  histogram_dump dump_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .dump_start    (dump_start),
    .dump_busy     (dump_busy),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast),
    .ram           (ram_b)
  );

endmodule

`default_nettype wire

// File: verification/histogram_tb.sv
`default_nettype none

`include "histogram_defs.svh"

module histogram_tb;
  import histogram_pkg::*;

  localparam int NUM_BINS = 1 << `HIST_ADDR_WIDTH;
  localparam int TIMEOUT_CYCLES = 20000; // Roughly four times the full run
  localparam bin_count_t MAX_COUNT = '1;

  logic       aclk;
  logic       aresetn;
  sample_t    s_axis_tdata;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  logic       dump_start;
  logic       dump_busy;
  bin_count_t m_axis_tdata;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  logic       m_axis_tlast;

  bin_count_t model [NUM_BINS];  // Expected count per bin
  bin_count_t dumped [NUM_BINS]; // Counts seen in the latest dump
  int         error_count;
  int         check_count;
  int         cycle_count;

  histogram_top dut_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .dump_start    (dump_start),
    .dump_busy     (dump_busy),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tlast  (m_axis_tlast)
  );

  initial
  begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge aclk);
      cycle_count++;
    end
    $display("ERROR: timeout, the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
    end
  endtask

  // All driving and sampling happens one time unit after the rising edge
  task automatic next_cycle();
    @(posedge aclk);
    #1;
  endtask

  task automatic send_sample(input sample_t data);
    bin_addr_t bin;
    bin = data[`HIST_ADDR_WIDTH-1:0];
    s_axis_tdata  = data;
    s_axis_tvalid = 1'b1;
    while (!s_axis_tready)
    begin
      next_cycle();
    end
    if (model[bin] != MAX_COUNT)
    begin
      model[bin] = model[bin] + 1'b1;
    end
    next_cycle(); // Beat taken at this edge
    s_axis_tvalid = 1'b0;
  endtask

  // Holds tvalid across several updates and watches the two-cycle gap
  task automatic send_burst(input sample_t data, input int count);
    bin_addr_t bin;
    bin = data[`HIST_ADDR_WIDTH-1:0];
    s_axis_tdata  = data;
    s_axis_tvalid = 1'b1;
    for (int i = 0; i < count; i++)
    begin
      while (!s_axis_tready)
      begin
        next_cycle();
      end
      if (model[bin] != MAX_COUNT)
      begin
        model[bin] = model[bin] + 1'b1;
      end
      next_cycle();
      check_value(32'(s_axis_tready), 32'd0, "tready low in first cycle after accept");
      next_cycle();
      check_value(32'(s_axis_tready), 32'd0, "tready low in second cycle after accept");
      next_cycle();
      check_value(32'(s_axis_tready), 32'd1, "tready back on third cycle after accept");
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic dump_and_check(input bit stall_mode);
    int         idx;
    int         stall_left;
    bit         done;
    bit         stalled;
    bin_count_t held_data;
    logic       held_last;
    idx        = 0;
    stall_left = 0;
    done       = 1'b0;
    stalled    = 1'b0;
    held_data  = '0;
    held_last  = 1'b0;
    check_value(32'(dump_busy), 32'd0, "dump engine idle before request");
    dump_start = 1'b1;
    next_cycle();
    dump_start = 1'b0;
    check_value(32'(dump_busy), 32'd1, "dump_busy high the cycle after dump_start");
    while (!done)
    begin
      if (stalled)
      begin
        check_value(32'(m_axis_tvalid), 32'd1, "tvalid held while stalled");
        check_value(32'(m_axis_tdata), 32'(held_data), "tdata stable while stalled");
        check_value(32'(m_axis_tlast), 32'(held_last), "tlast stable while stalled");
      end
      if (!stall_mode)
      begin
        m_axis_tready = 1'b1;
      end
      else if (stall_left > 0)
      begin
        m_axis_tready = 1'b0;
        stall_left--;
      end
      else if ($urandom % 3 == 0)
      begin
        m_axis_tready = 1'b0;
        stall_left    = 2 + $urandom % 6; // Stall for a few cycles in a row
      end
      else
      begin
        m_axis_tready = 1'b1;
      end
      stalled   = m_axis_tvalid && !m_axis_tready;
      held_data = m_axis_tdata;
      held_last = m_axis_tlast;
      if (m_axis_tvalid && m_axis_tready)
      begin
        dumped[idx] = m_axis_tdata;
        check_value(32'(m_axis_tdata), 32'(model[idx]), $sformatf("count of bin %0d", idx));
        check_value(32'(m_axis_tlast), 32'(idx == NUM_BINS - 1),
                    $sformatf("tlast on beat %0d", idx));
        done = m_axis_tlast || (idx == NUM_BINS - 1);
        idx++;
      end
      next_cycle();
    end
    m_axis_tready = 1'b0;
    check_value(32'(dump_busy), 32'd0, "dump_busy low after the tlast beat");
    check_value(32'(m_axis_tvalid), 32'd0, "tvalid low after the dump");
  endtask

  task automatic reset_and_clear();
    check_value(32'(s_axis_tready), 32'd0, "s_axis_tready low after reset");
    check_value(32'(m_axis_tvalid), 32'd0, "m_axis_tvalid low after reset");
    check_value(32'(m_axis_tlast), 32'd0, "m_axis_tlast low after reset");
    check_value(32'(dump_busy), 32'd0, "dump_busy low after reset");
    while (!s_axis_tready)
    begin
      next_cycle(); // Bins are being cleared
    end
    dump_and_check(1'b0);
  endtask

  task automatic distinct_bins();
    send_sample(16'h0003);
    send_sample(16'h0017);
    send_sample(16'hffc5);
    send_sample(16'h8040);
    send_sample(16'h123f);
    send_sample(16'h7f03);
    dump_and_check(1'b0);
  endtask

  task automatic back_to_back();
    send_burst(16'h0c07, 6);
    send_burst(16'hf021, 3);
    dump_and_check(1'b0);
  endtask

  // Random samples with all bins compared after every 50 of them
  task automatic random_batches();
    for (int i = 0; i < 300; i++)
    begin
      send_sample(sample_t'($urandom));
      if (i % 50 == 49)
      begin
        dump_and_check(1'b0);
      end
    end
  endtask

  task automatic saturation();
    for (int i = 0; i < 270; i++)
    begin
      send_sample(16'ha53c);
    end
    dump_and_check(1'b0);
    check_value(32'(dumped[6'h3c]), 32'hff, "saturated bin holds the maximum count");
  endtask

  task automatic stalled_dump();
    send_sample(16'h0001);
    send_sample(16'h0abe);
    dump_and_check(1'b1);
    dump_and_check(1'b1);
  endtask

  initial
  begin
    void'($urandom(69));
    error_count   = 0;
    check_count   = 0;
    aresetn       = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    dump_start    = 1'b0;
    m_axis_tready = 1'b0;
    for (int b = 0; b < NUM_BINS; b++)
    begin
      model[b]  = '0;
      dumped[b] = '0;
    end
    repeat (4) @(posedge aclk);
    #1;
    aresetn = 1'b1;

    reset_and_clear();
    distinct_bins();
    back_to_back();
    random_batches();
    saturation();
    stalled_dump();

    $display("Run finished after %0d cycles: %0d checks, %0d errors",
             cycle_count, check_count, error_count);
    if (error_count == 0)
    begin
      $display("Simulation completed successfully");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: histogram_top.f
+incdir+verilog
verilog/histogram_pkg.sv
verilog/bin_ram_if.sv
verilog/bin_ram.sv
verilog/axis_histogram.sv
verilog/histogram_dump.sv
verilog/histogram_top.sv
verification/histogram_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the histogram testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
  -f histogram_top.f \
  --top-module histogram_tb \
  --Mdir "$BUILD_DIR" \
  -o histogram_tb
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$BUILD_DIR/histogram_tb" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation executable returned status $run_status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
  exit 1
fi
exit 0
